// ==== design/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data path and address width
`define CPU_XLEN 32

// General register file
`define CPU_NREGS 16
`define CPU_RIDX_W 4

// Immediate, offset and direct value fields
`define CPU_IMM_W 20

// First fetch address after reset
`define CPU_RESET_IP 32'h0000_0000

`endif

// ==== design/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // Instruction phases
    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stExecute   = 3'd2,
        stMemory    = 3'd3,
        stWriteback = 3'd4,
        stSkip      = 3'd5,
        stHalt      = 3'd6
    } seqState;

    typedef enum logic [2:0] {
        clBranch   = 3'd0,
        clLoad     = 3'd1,
        clStore    = 3'd2,
        clDirect   = 3'd3,
        clDirectOr = 3'd4,
        clAlu      = 3'd5,
        clHalt     = 3'd6,
        clNop      = 3'd7
    } instClass;

    // ALU operation field, values 0 to 11 as in the ISA
    typedef enum logic [4:0] {
        opAdd  = 5'd0,
        opSub  = 5'd1,
        opAnd  = 5'd2,
        opOr   = 5'd3,
        opXor  = 5'd4,
        opNot  = 5'd5,
        opShl  = 5'd6,
        opAsr  = 5'd7,
        opShr  = 5'd8,
        opRor  = 5'd9,
        opRol  = 5'd10,
        opAndn = 5'd11,
        // Internal only, never decoded from an ALU instruction
        opPass = 5'd12
    } aluOp;

    typedef enum logic [3:0] {
        cAlways, cZero, cNotZero, cCarry, cNotCarry, cNeg, cNotNeg, cOver,
        cNotOver, cHigher, cLowerSame, cGreaterEq, cLess, cGreater, cLessEq, cNever
    } condCode;

endpackage

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module regFile (
    input  wire                    iClk,
    input  wire  [`CPU_RIDX_W-1:0] rdIdxA,
    input  wire  [`CPU_RIDX_W-1:0] rdIdxB,
    output logic [`CPU_XLEN-1:0]   rdDataA,
    output logic [`CPU_XLEN-1:0]   rdDataB,
    input  wire                    we,
    input  wire  [`CPU_RIDX_W-1:0] wrIdx,
    input  wire  [`CPU_XLEN-1:0]   wrData
);

    logic [`CPU_XLEN-1:0] regs [0:`CPU_NREGS-1];

    always_ff @(posedge iClk) begin
        if (we) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Registered reads, sampled every cycle
    always_ff @(posedge iClk) begin
        rdDataA <= regs[rdIdxA];
        rdDataB <= regs[rdIdxB];
    end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module alu (
    input  wire                  iClk,
    input  wire                  latchOps,
    input  wire  [`CPU_XLEN-1:0] rdDataA,
    input  wire  [`CPU_XLEN-1:0] rdDataB,
    input  wire  [`CPU_XLEN-1:0] operandImm,
    input  wire                  useImm,
    input  wire cpuPkg::aluOp    op,
    output logic [`CPU_XLEN-1:0] result,
    output logic [3:0]           flagsNext
);

    logic [`CPU_XLEN-1:0]   opA;
    logic [`CPU_XLEN-1:0]   opB;
    logic [`CPU_XLEN:0]     resReg;
    logic [`CPU_XLEN:0]     resNext;
    logic [`CPU_XLEN-1:0]   bSel;
    logic [4:0]             sh;
    logic [2*`CPU_XLEN-1:0] dbl;
    logic [2*`CPU_XLEN-1:0] dblRor;
    logic [2*`CPU_XLEN-1:0] dblRol;
    logic                   carry;
    logic                   zero;
    logic                   neg;
    logic                   over;

    assign bSel   = useImm ? operandImm : rdDataB;
    assign sh     = bSel[4:0];
    assign dbl    = {rdDataA, rdDataA};
    assign dblRor = dbl >> sh;
    assign dblRol = dbl << sh;

    always_comb begin
        case (op)
            cpuPkg::opAdd:  resNext = {1'b0, rdDataA} + {1'b0, bSel};
            cpuPkg::opSub:  resNext = {1'b0, rdDataA} - {1'b0, bSel};
            cpuPkg::opAnd:  resNext = {1'b0, rdDataA & bSel};
            cpuPkg::opOr:   resNext = {1'b0, rdDataA | bSel};
            cpuPkg::opXor:  resNext = {1'b0, rdDataA ^ bSel};
            cpuPkg::opNot:  resNext = {1'b0, ~rdDataA};
            cpuPkg::opShl:  resNext = {1'b0, rdDataA << sh};
            cpuPkg::opAsr:  resNext = {1'b0, $signed(rdDataA) >>> sh};
            cpuPkg::opShr:  resNext = {1'b0, rdDataA >> sh};
            cpuPkg::opRor:  resNext = {1'b0, dblRor[`CPU_XLEN-1:0]};
            cpuPkg::opRol:  resNext = {1'b0, dblRol[2*`CPU_XLEN-1:`CPU_XLEN]};
            cpuPkg::opAndn: resNext = {1'b0, rdDataA & ~bSel};
            cpuPkg::opPass: resNext = {1'b0, bSel};
            default:        resNext = '0;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (latchOps) begin
            opA    <= rdDataA;
            opB    <= bSel;
            resReg <= resNext;
        end
    end

    assign result = resReg[`CPU_XLEN-1:0];

    // Sub reports carry as not borrow
    assign carry = (op == cpuPkg::opAdd) ? resReg[`CPU_XLEN] :
                   (op == cpuPkg::opSub) ? ~resReg[`CPU_XLEN] : 1'b0;
    assign zero  = (resReg[`CPU_XLEN-1:0] == '0);
    assign neg   = resReg[`CPU_XLEN-1];
    assign over  = (op == cpuPkg::opAdd) ?
                   ((opA[31] == opB[31]) && (resReg[31] != opA[31])) :
                   (op == cpuPkg::opSub) ?
                   ((opA[31] != opB[31]) && (resReg[31] != opA[31])) : 1'b0;

    assign flagsNext = {carry, zero, neg, over};

endmodule

`default_nettype wire

// ==== design/flagUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module flagUnit (
    input  wire                  iClk,
    input  wire                  rstN,
    input  wire                  flagWe,
    input  wire  [3:0]           flagsNext,
    input  wire cpuPkg::condCode cond,
    output logic                 taken
);

    // Flag order is C, Z, N, V
    logic [3:0] flags;
    logic       fC;
    logic       fZ;
    logic       fN;
    logic       fV;

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            flags <= 4'b0000;
        end else if (flagWe) begin
            flags <= flagsNext;
        end
    end

    assign fC = flags[3];
    assign fZ = flags[2];
    assign fN = flags[1];
    assign fV = flags[0];

    always_comb begin
        case (cond)
            cpuPkg::cAlways:    taken = 1'b1;
            cpuPkg::cZero:      taken = fZ;
            cpuPkg::cNotZero:   taken = !fZ;
            cpuPkg::cCarry:     taken = fC;
            cpuPkg::cNotCarry:  taken = !fC;
            cpuPkg::cNeg:       taken = fN;
            cpuPkg::cNotNeg:    taken = !fN;
            cpuPkg::cOver:      taken = fV;
            cpuPkg::cNotOver:   taken = !fV;
            cpuPkg::cHigher:    taken = fC && !fZ;
            cpuPkg::cLowerSame: taken = !fC || fZ;
            cpuPkg::cGreaterEq: taken = (fN == fV);
            cpuPkg::cLess:      taken = (fN != fV);
            cpuPkg::cGreater:   taken = !fZ && (fN == fV);
            cpuPkg::cLessEq:    taken = fZ || (fN != fV);
            default:            taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/instDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module instDecode (
    input  wire  [`CPU_XLEN-1:0]   inst,
    output cpuPkg::instClass       cls,
    output logic [`CPU_RIDX_W-1:0] rdIdxA,
    output logic [`CPU_RIDX_W-1:0] rdIdxB,
    output logic [`CPU_RIDX_W-1:0] wrIdx,
    output cpuPkg::aluOp           op,
    output cpuPkg::condCode        cond,
    output logic                   useImm,
    output logic [`CPU_XLEN-1:0]   operandImm
);

    logic [`CPU_IMM_W-1:0] field20;
    logic [`CPU_XLEN-1:0]  zext20;
    logic [`CPU_XLEN-1:0]  sext20;
    logic [`CPU_XLEN-1:0]  zext8;
    logic                  aluOpValid;

    assign field20    = inst[`CPU_IMM_W-1:0];
    assign zext20     = {{(`CPU_XLEN-`CPU_IMM_W){1'b0}}, field20};
    assign sext20     = {{(`CPU_XLEN-`CPU_IMM_W){field20[`CPU_IMM_W-1]}}, field20};
    assign zext8      = {{(`CPU_XLEN-8){1'b0}}, inst[7:0]};
    assign aluOpValid = (inst[24:20] <= 5'd11);
    assign cond       = cpuPkg::condCode'(inst[27:24]);

    always_comb begin
        cls        = cpuPkg::clNop;
        rdIdxA     = inst[15:12];
        rdIdxB     = inst[11:8];
        wrIdx      = inst[19:16];
        op         = cpuPkg::opAdd;
        useImm     = 1'b1;
        operandImm = zext20;
        if (inst[31]) begin
            cls        = cpuPkg::clBranch;
            rdIdxA     = inst[23:20];
            operandImm = sext20;
        end else if (inst[30]) begin
            cls    = inst[29] ? cpuPkg::clStore : cpuPkg::clLoad;
            rdIdxA = inst[27:24];
            rdIdxB = inst[23:20];
            wrIdx  = inst[23:20];
        end else if (inst[29]) begin
            // Value shifted left by twice the shift field
            cls        = inst[28] ? cpuPkg::clDirectOr : cpuPkg::clDirect;
            rdIdxA     = inst[27:24];
            wrIdx      = inst[27:24];
            op         = inst[28] ? cpuPkg::opOr : cpuPkg::opPass;
            operandImm = zext20 << {inst[23:20], 1'b0};
        end else if (inst[28]) begin
            cls        = aluOpValid ? cpuPkg::clAlu : cpuPkg::clNop;
            op         = aluOpValid ? cpuPkg::aluOp'(inst[24:20]) : cpuPkg::opAdd;
            useImm     = inst[27];
            operandImm = zext8 << {inst[11:8], 1'b0};
        end else if (inst[27:26] == 2'b01) begin
            // Core op 2 halts, the rest do nothing
            cls = (inst[25:20] == 6'd2) ? cpuPkg::clHalt : cpuPkg::clNop;
        end
    end

endmodule

`default_nettype wire

// ==== design/seqControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module seqControl (
    input  wire                   iClk,
    input  wire                   rstN,
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic                  wbWe,
    output logic [`CPU_XLEN-1:0]  wbAdr,
    output logic [`CPU_XLEN-1:0]  wbDatO,
    input  wire  [`CPU_XLEN-1:0]  wbDatI,
    input  wire                   wbAck,
    output logic                  halt,
    output logic [`CPU_XLEN-1:0]  inst,
    input  wire cpuPkg::instClass cls,
    input  wire                   taken,
    input  wire  [`CPU_XLEN-1:0]  aluResult,
    input  wire  [`CPU_XLEN-1:0]  storeData,
    output logic                  latchOps,
    output logic                  regWe,
    output logic [`CPU_XLEN-1:0]  regWrData,
    output logic                  flagWe
);

    cpuPkg::seqState      state;
    logic [`CPU_XLEN-1:0] ip;
    logic [`CPU_XLEN-1:0] instReg;
    logic [`CPU_XLEN-1:0] loadWord;
    logic                 isMem;
    logic                 busDone;

    assign isMem   = (cls == cpuPkg::clLoad) || (cls == cpuPkg::clStore);
    assign busDone = wbCyc && wbAck;

    // Bus outputs follow the phase; cyc itself is registered
    assign wbStb  = wbCyc;
    assign wbWe   = (state == cpuPkg::stMemory) && (cls == cpuPkg::clStore);
    assign wbAdr  = (state == cpuPkg::stMemory) ? aluResult : ip;
    assign wbDatO = storeData;

    assign halt      = (state == cpuPkg::stHalt);
    assign inst      = instReg;
    assign latchOps  = (state == cpuPkg::stExecute);
    assign flagWe    = (state == cpuPkg::stWriteback) && (cls == cpuPkg::clAlu);
    assign regWe     = (state == cpuPkg::stWriteback) &&
                       ((cls == cpuPkg::clLoad) || (cls == cpuPkg::clDirect) ||
                        (cls == cpuPkg::clDirectOr) || (cls == cpuPkg::clAlu));
    assign regWrData = (cls == cpuPkg::clLoad) ? loadWord : aluResult;

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            state <= cpuPkg::stFetch;
            ip    <= `CPU_RESET_IP;
            wbCyc <= 1'b0;
        end else begin
            case (state)
                cpuPkg::stFetch: begin
                    // Only idle here right after reset
                    if (!wbCyc) begin
                        wbCyc <= 1'b1;
                    end else if (wbAck) begin
                        wbCyc <= 1'b0;
                        state <= cpuPkg::stDecode;
                    end
                end
                cpuPkg::stDecode: begin
                    state <= cpuPkg::stExecute;
                end
                cpuPkg::stExecute: begin
                    state <= cpuPkg::stMemory;
                    if (isMem) begin
                        wbCyc <= 1'b1;
                    end
                end
                cpuPkg::stMemory: begin
                    if (!isMem) begin
                        if (cls == cpuPkg::clBranch && !taken) begin
                            state <= cpuPkg::stSkip;
                        end else begin
                            state <= cpuPkg::stWriteback;
                        end
                    end else if (wbAck) begin
                        wbCyc <= 1'b0;
                        state <= cpuPkg::stWriteback;
                    end
                end
                cpuPkg::stWriteback: begin
                    // Branch target is base plus offset from the ALU
                    if (cls == cpuPkg::clBranch) begin
                        ip <= aluResult;
                    end else begin
                        ip <= ip + 1'b1;
                    end
                    if (cls == cpuPkg::clHalt) begin
                        state <= cpuPkg::stHalt;
                    end else begin
                        state <= cpuPkg::stFetch;
                        wbCyc <= 1'b1;
                    end
                end
                cpuPkg::stSkip: begin
                    ip    <= ip + 1'b1;
                    state <= cpuPkg::stFetch;
                    wbCyc <= 1'b1;
                end
                cpuPkg::stHalt: begin
                    state <= cpuPkg::stHalt;
                end
                default: begin
                    state <= cpuPkg::stFetch;
                    wbCyc <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge iClk) begin
        if (state == cpuPkg::stFetch && busDone) begin
            instReg <= wbDatI;
        end
        if (state == cpuPkg::stMemory && busDone) begin
            loadWord <= wbDatI;
        end
    end

endmodule

`default_nettype wire

// ==== design/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpuTop (
    input  wire                  iClk,
    input  wire                  rstN,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output logic [`CPU_XLEN-1:0] wbAdr,
    output logic [`CPU_XLEN-1:0] wbDatO,
    input  wire  [`CPU_XLEN-1:0] wbDatI,
    input  wire                  wbAck,
    output logic                 halt
);

    logic [`CPU_XLEN-1:0]   inst;
    cpuPkg::instClass       cls;
    cpuPkg::aluOp           op;
    cpuPkg::condCode        cond;
    logic [`CPU_RIDX_W-1:0] rdIdxA;
    logic [`CPU_RIDX_W-1:0] rdIdxB;
    logic [`CPU_RIDX_W-1:0] wrIdx;
    logic                   useImm;
    logic [`CPU_XLEN-1:0]   operandImm;
    logic [`CPU_XLEN-1:0]   rdDataA;
    logic [`CPU_XLEN-1:0]   rdDataB;
    logic [`CPU_XLEN-1:0]   aluResult;
    logic [`CPU_XLEN-1:0]   regWrData;
    logic [3:0]             flagsNext;
    logic                   latchOps;
    logic                   regWe;
    logic                   flagWe;
    logic                   taken;

    seqControl u_seq (
        .iClk(iClk), .rstN(rstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
        .wbDatI(wbDatI), .wbAck(wbAck), .halt(halt),
        .inst(inst), .cls(cls), .taken(taken),
        .aluResult(aluResult), .storeData(rdDataB),
        .latchOps(latchOps), .regWe(regWe), .regWrData(regWrData), .flagWe(flagWe)
    );

    instDecode u_dec (
        .inst(inst), .cls(cls), .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .wrIdx(wrIdx),
        .op(op), .cond(cond), .useImm(useImm), .operandImm(operandImm)
    );

    regFile u_regs (
        .iClk(iClk), .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .we(regWe), .wrIdx(wrIdx), .wrData(regWrData)
    );

    alu u_alu (
        .iClk(iClk), .latchOps(latchOps), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .operandImm(operandImm), .useImm(useImm), .op(op),
        .result(aluResult), .flagsNext(flagsNext)
    );

    flagUnit u_flags (
        .iClk(iClk), .rstN(rstN), .flagWe(flagWe), .flagsNext(flagsNext),
        .cond(cond), .taken(taken)
    );

endmodule

`default_nettype wire

// ==== testbench/cpu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuChk (
    input wire        iClk,
    input wire        rstN,
    input wire        wbCyc,
    input wire        wbStb,
    input wire        wbAck,
    input wire [31:0] wbAdr,
    input wire        halt
);

    stbInCyc: assert property (@(posedge iClk) disable iff (!rstN) wbStb |-> wbCyc)
        else $error("wbStb high while wbCyc is low");

    // Held through wait states until ack
    adrHeld: assert property (@(posedge iClk) disable iff (!rstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr)))
        else $error("wbAdr or wbStb changed during a wait state");

    haltSticky: assert property (@(posedge iClk) $fell(halt) |-> !rstN)
        else $error("halt fell without reset");

    idleAfterReset: assert property (@(posedge iClk) !rstN |=> !wbCyc)
        else $error("wbCyc high in the cycle after reset");

endmodule

bind cpuTop cpuChk u_chk (
    .iClk(iClk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb),
    .wbAck(wbAck), .wbAdr(wbAdr), .halt(halt)
);

`default_nettype wire

// ==== testbench/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    logic        iClk;
    logic        rstN;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [31:0] wbAdr;
    logic [31:0] wbDatO;
    logic [31:0] wbDatI;
    logic        wbAck;
    logic        halt;

    logic [31:0] mem [0:255];
    logic [31:0] modelMem [0:255];
    logic [31:0] model [0:15];
    logic [3:0]  flags;
    logic [7:0]  pc;
    logic        skipNext;
    logic [31:0] lfsr;
    logic [63:0] expQ [$];
    logic [63:0] gotQ [$];
    logic        busy;
    logic [1:0]  waitLeft;
    int          errCount;
    int          testErr;
    int          passCount;
    int          failCount;

    // Operands of the flag-setting op before the branches
    localparam logic [31:0] flagSetA [5] = '{32'd5, 32'd3, 32'h7fff_ffff, 32'hffff_ffff,
                                             32'h8000_0000};
    localparam logic [31:0] flagSetB [5] = '{32'd5, 32'd5, 32'd1, 32'd2, 32'd1};
    localparam logic [4:0]  flagSetAdd = 5'b01100;

    cpuTop u_cpuTop (
        .iClk(iClk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck), .halt(halt)
    );

    initial iClk = 1'b0;
    always #20 iClk = ~iClk;

    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = nextLfsr(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] refExec(input logic [4:0] op, input logic [31:0] a,
                                            input logic [31:0] b, output logic [3:0] f);
        logic [32:0] wide;
        logic [4:0]  s;
        logic [31:0] r;
        logic        c;
        logic        v;
        c = 1'b0;
        v = 1'b0;
        s = b[4:0];
        case (op)
            cpuPkg::opAdd: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[31:0];
                c = wide[32];
                v = (a[31] == b[31]) && (r[31] != a[31]);
            end
            cpuPkg::opSub: begin
                r = a - b;
                c = (a >= b);
                v = (a[31] != b[31]) && (r[31] != a[31]);
            end
            cpuPkg::opAnd:  r = a & b;
            cpuPkg::opOr:   r = a | b;
            cpuPkg::opXor:  r = a ^ b;
            cpuPkg::opNot:  r = ~a;
            cpuPkg::opShl:  r = a << s;
            cpuPkg::opAsr:  r = $signed(a) >>> s;
            cpuPkg::opShr:  r = a >> s;
            cpuPkg::opRor:  r = (s == 5'd0) ? a : ((a >> s) | (a << (6'd32 - {1'b0, s})));
            cpuPkg::opRol:  r = (s == 5'd0) ? a : ((a << s) | (a >> (6'd32 - {1'b0, s})));
            cpuPkg::opAndn: r = a & ~b;
            default:        r = a;
        endcase
        f = {c, (r == 32'h0), r[31], v};
        return r;
    endfunction

    // Flags are {C, Z, N, V}
    function automatic logic refTaken(input logic [3:0] cond, input logic [3:0] f);
        case (cond)
            cpuPkg::cAlways:    return 1'b1;
            cpuPkg::cZero:      return f[2];
            cpuPkg::cNotZero:   return !f[2];
            cpuPkg::cCarry:     return f[3];
            cpuPkg::cNotCarry:  return !f[3];
            cpuPkg::cNeg:       return f[1];
            cpuPkg::cNotNeg:    return !f[1];
            cpuPkg::cOver:      return f[0];
            cpuPkg::cNotOver:   return !f[0];
            cpuPkg::cHigher:    return f[3] && !f[2];
            cpuPkg::cLowerSame: return !f[3] || f[2];
            cpuPkg::cGreaterEq: return f[1] == f[0];
            cpuPkg::cLess:      return f[1] != f[0];
            cpuPkg::cGreater:   return !f[2] && (f[1] == f[0]);
            cpuPkg::cLessEq:    return f[2] || (f[1] != f[0]);
            default:            return 1'b0;
        endcase
    endfunction

    task automatic reportProblem(input string msg);
        $display("[ERROR] %0t ns %s", $time, msg);
        errCount++;
        testErr++;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s got %08h expected %08h", $time, name, got, exp);
            errCount++;
            testErr++;
        end
    endtask

    task automatic put(input logic [31:0] w);
        mem[pc] = w;
        pc = pc + 8'd1;
    endtask

    task automatic emitDirect(input logic orForm, input logic [3:0] d, input logic [3:0] sh,
                              input logic [19:0] val);
        logic [31:0] operand;
        operand = {12'h000, val} << {sh, 1'b0};
        model[d] = orForm ? (model[d] | operand) : operand;
        put({3'b001, orForm, d, sh, val});
    endtask

    task automatic loadConst(input logic [3:0] d, input logic [31:0] x);
        emitDirect(1'b0, d, 4'd10, {8'h00, x[31:20]});
        emitDirect(1'b1, d, 4'd0, x[19:0]);
    endtask

    task automatic emitAlu(input logic imm, input logic [4:0] op, input logic [3:0] d,
                           input logic [3:0] a, input logic [3:0] b, input logic [7:0] imm8);
        logic [31:0] bv;
        logic [3:0]  f;
        bv = imm ? ({24'h0, imm8} << {b, 1'b0}) : model[b];
        model[d] = refExec(op, model[a], bv, f);
        flags = f;
        put({4'b0001, imm, 2'b00, op, d, a, b, imm8});
    endtask

    task automatic emitStore(input logic [3:0] base, input logic [3:0] r, input logic [19:0] off);
        logic [31:0] addr;
        addr = model[base] + {12'h000, off};
        if (!skipNext) begin
            expQ.push_back({addr, model[r]});
            modelMem[addr[7:0]] = model[r];
        end
        skipNext = 1'b0;
        put({2'b01, 1'b1, 1'b0, base, r, off});
    endtask

    task automatic emitLoad(input logic [3:0] base, input logic [3:0] r, input logic [19:0] off);
        logic [31:0] addr;
        addr = model[base] + {12'h000, off};
        model[r] = modelMem[addr[7:0]];
        put({2'b01, 1'b0, 1'b0, base, r, off});
    endtask

    // Branch over the next instruction relative to r15 at zero
    task automatic emitBranch(input logic [3:0] cond);
        skipNext = refTaken(cond, flags);
        put({1'b1, 3'b000, cond, 4'd15, 12'h000, pc + 8'd2});
    endtask

    task automatic emitHalt();
        put({6'b000001, 6'd2, 20'h00000});
    endtask

    task automatic startProgram();
        rstN <= 1'b0;
        @(negedge iClk);
        gotQ.delete();
        expQ.delete();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'h5a, 16'h0000, 8'(i)};
            modelMem[i] = {8'h5a, 16'h0000, 8'(i)};
        end
        pc = 8'd0;
        skipNext = 1'b0;
        emitDirect(1'b0, 4'd15, 4'd0, 20'h00000);
    endtask

    task automatic runProgram();
        int cycles;
        repeat (2) @(negedge iClk);
        rstN <= 1'b1;
        checkValue("wbCyc", 32'(wbCyc), 32'h0);
        checkValue("halt", 32'(halt), 32'h0);
        cycles = 0;
        while (!wbCyc && cycles < 8) begin
            @(negedge iClk);
            cycles++;
        end
        assert (wbCyc) else reportProblem("no fetch started after reset");
        checkValue("wbAdr", wbAdr, 32'h0);
        cycles = 0;
        while (!halt && cycles < 3000) begin
            @(negedge iClk);
            cycles++;
        end
        assert (halt) else reportProblem("core hung, halt never rose");
        cycles = 0;
        while (!wbCyc && cycles < 20) begin
            @(negedge iClk);
            cycles++;
        end
        assert (!wbCyc) else reportProblem("bus cycle started after halt");
        assert (expQ.size() == 0) else reportProblem("expected stores never happened");
    endtask

    task automatic finishTest(input string name);
        if (testErr == 0) begin
            passCount++;
            $display("%s: passed", name);
        end else begin
            failCount++;
            $display("%s: %0d errors", name, testErr);
        end
        testErr = 0;
    endtask

    // Wishbone slave with 0 to 3 wait cycles
    always @(negedge iClk) begin
        if (!rstN) begin
            wbAck <= 1'b0;
            busy = 1'b0;
        end else if (wbAck) begin
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!busy) begin
                busy = 1'b1;
                waitLeft = 2'(randBits(2));
            end
            if (waitLeft == 2'd0) begin
                busy = 1'b0;
                wbAck <= 1'b1;
                if (wbWe) begin
                    mem[wbAdr[7:0]] = wbDatO;
                    gotQ.push_back({wbAdr, wbDatO});
                end else begin
                    wbDatI <= mem[wbAdr[7:0]];
                end
            end else begin
                waitLeft = waitLeft - 2'd1;
            end
        end
    end

    // Stores recorded on the falling edge get checked on the next rising edge
    always @(posedge iClk) begin
        logic [63:0] got;
        logic [63:0] exp;
        if (gotQ.size() > 0) begin
            got = gotQ.pop_front();
            assert (expQ.size() > 0) else reportProblem("store seen with no expected store left");
            if (expQ.size() > 0) begin
                exp = expQ.pop_front();
                checkValue("wbAdr", got[63:32], exp[63:32]);
                checkValue("wbDatO", got[31:0], exp[31:0]);
            end
        end
    end

    initial begin
        logic [4:0]  op;
        logic [5:0]  off;
        lfsr = 32'h97560e33;
        rstN = 1'b0;
        wbAck = 1'b0;
        wbDatI = 32'h0;
        busy = 1'b0;
        waitLeft = 2'd0;
        flags = 4'h0;
        errCount = 0;
        testErr = 0;
        passCount = 0;
        failCount = 0;

        startProgram();
        loadConst(4'd1, 32'hcafe_0001);
        emitStore(4'd15, 4'd1, 20'h000c0);
        emitHalt();
        runProgram();
        finishTest("reset and first fetch");

        for (int run = 0; run < 3; run++) begin
            startProgram();
            loadConst(4'd1, randBits(32));
            loadConst(4'd2, randBits(32));
            for (int k = 0; k < 12; k++) begin
                emitAlu(1'b0, 5'(k), 4'd3, 4'd1, 4'd2, 8'h00);
                emitStore(4'd15, 4'd3, 20'(32'hc0 + k));
            end
            emitHalt();
            runProgram();
        end
        finishTest("register ALU operations");

        startProgram();
        loadConst(4'd1, randBits(32));
        for (int k = 0; k < 8; k++) begin
            op = 5'(randBits(4) % 12);
            emitAlu(1'b1, op, 4'd3, 4'd1, 4'(randBits(4)), 8'(randBits(8)));
            emitStore(4'd15, 4'd3, 20'(32'hc0 + k));
            emitDirect(1'b1, 4'd1, 4'(randBits(4)), 20'(randBits(20)));
            emitStore(4'd15, 4'd1, 20'(32'hd0 + k));
        end
        emitHalt();
        runProgram();
        finishTest("immediate ALU and direct OR");

        startProgram();
        emitDirect(1'b0, 4'd6, 4'd0, 20'h00080);
        for (int k = 0; k < 4; k++) begin
            loadConst(4'd5, randBits(32));
            off = 6'(randBits(6));
            emitStore(4'd6, 4'd5, {14'h0, off});
            emitLoad(4'd6, 4'd7, {14'h0, off});
            emitStore(4'd15, 4'd7, 20'(32'hc0 + k));
        end
        emitHalt();
        runProgram();
        finishTest("load and store round trip");

        for (int s = 0; s < 5; s++) begin
            startProgram();
            loadConst(4'd1, flagSetA[s]);
            loadConst(4'd2, flagSetB[s]);
            op = flagSetAdd[s] ? cpuPkg::opAdd : cpuPkg::opSub;
            emitAlu(1'b0, op, 4'd3, 4'd1, 4'd2, 8'h00);
            emitDirect(1'b0, 4'd8, 4'd0, 20'(s));
            for (int c = 0; c < 16; c++) begin
                emitBranch(4'(c));
                emitStore(4'd15, 4'd8, 20'(32'hc0 + c));
            end
            emitStore(4'd15, 4'd3, 20'h000d0);
            emitHalt();
            runProgram();
        end
        finishTest("branch conditions");

        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
        if (errCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/cpuPkg.sv
design/regFile.sv
design/alu.sv
design/flagUnit.sv
design/instDecode.sv
design/seqControl.sv
design/cpuTop.sv
testbench/cpu_chk.sv
testbench/cpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAILED
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
